//--- mem_block.f
source/mem_pkg.sv
source/mem_issue.sv
source/mem_bank.sv
source/mem_writeback.sv
source/mem_block.sv
verification/mem_block_tb.sv

//--- Makefile
# Verilator flow for the memory-access stage

VERILATOR  ?= verilator
TOP        ?= mem_block_tb
FILELIST   ?= mem_block.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
BUILD_OPTS ?= -Wno-fatal
SIM_ARGS   ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_OPTS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mem_block_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_block_tb import mem_pkg::*; ();

  localparam logic [31:0] SEED = 32'd75864;
  localparam int ADDR_W    = WORD_IDX_W + 2;
  localparam int MEM_BYTES = 1 << ADDR_W;
  localparam int N_FILL    = NUM_BANKS * BANK_WORDS;
  localparam int N_WORD    = 40;
  localparam int N_SUB     = 16;
  localparam int N_MIS     = 16;
  localparam int N_ATOM    = 8;
  localparam int N_RAND    = 300;
  localparam int N_FLUSH   = 4;
  localparam int TOTAL_OPS = N_FILL + 2*N_WORD + 9*N_SUB + 4*N_MIS + 10*N_ATOM + N_RAND
                             + 3*N_FLUSH;

  logic     clk;
  logic     rst_n;
  logic     flush_i;
  exe_req_t exe_i;
  logic     exe_ready_o;
  wb_t      wb_o;
  logic     wb_ready_i;

  // Reference model state
  logic [7:0]            mem_model [MEM_BYTES];
  logic                  resv_v;
  logic [WORD_IDX_W-1:0] resv_word;
  wb_t                   exp_q [$];

  logic [31:0]      stim_state;
  logic [31:0]      ready_state;
  logic             ready_rand;
  logic [ROB_W-1:0] rob_ctr;
  string            cur_test;
  int               errors;
  int               checks;
  int               tests_run;
  int               tests_failed;
  int               test_err0;

  mem_block dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .exe_i       (exe_i),
    .exe_ready_o (exe_ready_o),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
  );

  always #5 clk = ~clk;

  // ============================================================
  // Random numbers and helpers
  // ============================================================
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Halves swapped so the weak low bits are not used directly
  function automatic logic [31:0] stim_rand();
    stim_state = lcg_step(stim_state);
    return {stim_state[15:0], stim_state[31:16]};
  endfunction

  function automatic logic [31:0] fill_word(input int w);
    logic [31:0] wv;
    wv = w;
    return (wv * 32'h9E3779B1) ^ 32'hA5C3_0F17;
  endfunction

  function automatic string fmt_wb(input wb_t w);
    return $sformatf("v=%0b we=%0b wdata=%h rob=%0d pdest=%0d excp=%0b vaddr=%h op=%0d at=%0b",
                     w.valid, w.we, w.wdata, w.rob_idx, w.pdest, w.excp, w.vaddr,
                     w.mem_op, w.atomic);
  endfunction

  task automatic check_wb(input wb_t exp, input wb_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %s actual %s", cur_test, fmt_wb(exp), fmt_wb(act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: %s expected %0b actual %0b", cur_test, what, exp, act);
    end
  endtask

  // ============================================================
  // Reference model, updated when an operation is accepted
  // ============================================================
  task automatic model_accept(input exe_req_t r);
    logic [31:0]           addr;
    logic [1:0]            off;
    logic [WORD_IDX_W-1:0] w;
    logic [7:0]            b0;
    logic [7:0]            b1;
    logic                  mis;
    logic                  ok;
    wb_t                   e;
    addr = r.src0 + r.imm;
    off  = addr[1:0];
    w    = addr[2 +: WORD_IDX_W];
    mis  = (r.align == ALIGN_H) ? off[0] : (r.align == ALIGN_W) ? (off != 2'b00) : 1'b0;
    e         = '0;
    e.valid   = 1'b1;
    e.rob_idx = r.rob_idx;
    e.pdest   = r.pdest;
    e.vaddr   = addr;
    e.mem_op  = r.mem_op;
    e.atomic  = r.atomic;
    e.excp    = mis;
    if (mis) begin
      if (r.mem_op == MEM_STORE && r.atomic) resv_v = 1'b0;
    end else if (r.mem_op == MEM_LOAD) begin
      b0   = mem_model[{w, off}];
      b1   = mem_model[{w, off | 2'b01}];
      e.we = 1'b1;
      case (r.align)
        ALIGN_B: e.wdata = r.sign_ext ? {{24{b0[7]}}, b0} : {24'h0, b0};
        ALIGN_H: e.wdata = r.sign_ext ? {{16{b1[7]}}, b1, b0} : {16'h0, b1, b0};
        default: e.wdata = {mem_model[{w, 2'd3}], mem_model[{w, 2'd2}],
                            mem_model[{w, 2'd1}], mem_model[{w, 2'd0}]};
      endcase
      if (r.atomic) begin
        resv_v    = 1'b1;
        resv_word = w;
      end
    end else begin
      ok = 1'b1;
      if (r.atomic) begin
        ok      = resv_v && (resv_word == w);
        resv_v  = 1'b0;
        e.we    = 1'b1;
        e.wdata = {31'h0, ok};
      end else if (resv_word == w) begin
        resv_v = 1'b0;
      end
      if (ok) begin
        mem_model[{w, off}] = r.src1[7:0];
        if (r.align != ALIGN_B) mem_model[{w, off | 2'b01}] = r.src1[15:8];
        if (r.align == ALIGN_W) begin
          mem_model[{w, 2'd2}] = r.src1[23:16];
          mem_model[{w, 2'd3}] = r.src1[31:24];
        end
      end
    end
    exp_q.push_back(e);
  endtask

  // ============================================================
  // Stimulus tasks
  // ============================================================
  // Called 1 ns after a rising edge, returns at the same point
  task automatic send_op(input mem_op_e op, input align_e al, input logic sx, input logic at,
                         input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] base;
    logic [31:0] r;
    base = stim_rand();
    r    = stim_rand();
    exe_i.valid    = 1'b1;
    exe_i.mem_op   = op;
    exe_i.align    = al;
    exe_i.sign_ext = sx;
    exe_i.atomic   = at;
    exe_i.src0     = base;
    exe_i.imm      = addr - base;
    exe_i.src1     = data;
    exe_i.rob_idx  = rob_ctr;
    exe_i.pdest    = PREG_W'(r);
    rob_ctr        = rob_ctr + ROB_W'(1);
    @(negedge clk);
    while (!exe_ready_o) @(negedge clk);
    model_accept(exe_i);
    @(posedge clk);
    #1;
    exe_i.valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic finish_test();
    wait_drain();
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", cur_test, errors - test_err0);
    end else begin
      $display("%s: ok", cur_test);
    end
  endtask

  // ============================================================
  // Writeback monitor, ready driver and watchdog
  // ============================================================
  always @(negedge clk) begin
    if (rst_n && wb_o.valid && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Writeback record appeared with no operation outstanding in %s", cur_test);
      end else begin
        check_wb(exp_q.pop_front(), wb_o);
      end
    end
  end

  always @(posedge clk) begin
    #1;
    ready_state = lcg_step(ready_state);
    wb_ready_i  = ready_rand ? (ready_state[20:18] > 3'd2) : 1'b1;
  end

  initial begin
    repeat (TOTAL_OPS * 40) @(posedge clk);
    $display("Watchdog expired after %0d cycles during %s", TOTAL_OPS * 40, cur_test);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    logic [31:0] r;
    logic [31:0] wa;
    logic [31:0] wb2;
    logic [31:0] d;
    logic [31:0] addr;
    mem_op_e     op;
    align_e      al;
    clk = 1'b0;
    rst_n = 1'b0;
    flush_i = 1'b0;
    exe_i = '0;
    wb_ready_i = 1'b1;
    ready_rand = 1'b0;
    stim_state = SEED;
    ready_state = ~SEED;
    resv_v = 1'b0;
    resv_word = '0;
    rob_ctr = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    cur_test = "reset";

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    start_test("reset");
    @(negedge clk);
    check_bit("exe_ready_o", 1'b1, exe_ready_o);
    check_bit("wb_o.valid", 1'b0, wb_o.valid);
    @(posedge clk);
    #1;
    finish_test();

    // Every word gets a known value before any read
    start_test("fill");
    for (int w = 0; w < N_FILL; w++) begin
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b0, 32'(w) << 2, fill_word(w));
    end
    finish_test();

    start_test("word_store_load");
    for (int i = 0; i < N_WORD; i++) begin
      r = stim_rand();
      addr = {r[31:2], 2'b00};
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b0, addr, stim_rand());
      send_op(MEM_LOAD, ALIGN_W, r[0], 1'b0, addr, 32'h0);
    end
    finish_test();

    start_test("byte_half");
    for (int i = 0; i < N_SUB; i++) begin
      r = stim_rand();
      d = stim_rand();
      wa = {r[31:2], 2'b00};
      send_op(MEM_STORE, ALIGN_B, 1'b0, 1'b0, wa | 32'(d[9:8]), d);
      send_op(MEM_STORE, ALIGN_H, 1'b0, 1'b0, wa | 32'({d[17], 1'b0}), stim_rand());
      for (int o = 0; o < 4; o++) begin
        send_op(MEM_LOAD, ALIGN_B, d[24+o], 1'b0, wa + 32'(o), 32'h0);
      end
      send_op(MEM_LOAD, ALIGN_H, d[28], 1'b0, wa, 32'h0);
      send_op(MEM_LOAD, ALIGN_H, d[29], 1'b0, wa + 32'd2, 32'h0);
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, wa, 32'h0);
    end
    finish_test();

    start_test("misaligned");
    for (int i = 0; i < N_MIS; i++) begin
      r = stim_rand();
      wa = {r[31:5], 5'b00000};
      addr = wa | ((r[4:3] == 2'b00) ? 32'd1 : 32'(r[4:3]));
      send_op(MEM_STORE, ALIGN_H, 1'b0, 1'b0, wa | 32'({r[2], 1'b1}), stim_rand());
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b0, addr, stim_rand());
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, addr, 32'h0);
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, wa, 32'h0);
    end
    finish_test();

    start_test("ll_sc");
    for (int i = 0; i < N_ATOM; i++) begin
      r = stim_rand();
      wa = {r[31:2], 2'b00};
      wb2 = wa ^ 32'h4;
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b1, wa, 32'h0);
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b1, wa, stim_rand());
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, wa, 32'h0);
      // Intervening store kills the reservation
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b1, wa, 32'h0);
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b0, wa, stim_rand());
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b1, wa, stim_rand());
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, wa, 32'h0);
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b1, wa, 32'h0);
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b1, wb2, stim_rand());
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, wb2, 32'h0);
    end
    finish_test();

    start_test("random_backpressure");
    ready_rand = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      r = stim_rand();
      op = r[0] ? MEM_STORE : MEM_LOAD;
      al = (r[2:1] == 2'd0) ? ALIGN_B : (r[2:1] == 2'd1) ? ALIGN_H : ALIGN_W;
      addr = stim_rand();
      if (r[7]) addr[1:0] = 2'b00;
      send_op(op, al, r[6], r[5:3] == 3'd0, addr, stim_rand());
    end
    wait_drain();
    ready_rand = 1'b0;
    finish_test();

    start_test("flush_resv");
    for (int i = 0; i < N_FLUSH; i++) begin
      r = stim_rand();
      wa = {r[31:2], 2'b00};
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b1, wa, 32'h0);
      wait_drain();
      flush_i = 1'b1;
      resv_v = 1'b0;
      @(posedge clk);
      #1;
      flush_i = 1'b0;
      send_op(MEM_STORE, ALIGN_W, 1'b0, 1'b1, wa, stim_rand());
      send_op(MEM_LOAD, ALIGN_W, 1'b0, 1'b0, wa, 32'h0);
    end
    finish_test();

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/mem_block.sv
`timescale 1ns/100ps
`default_nettype none

module mem_block import mem_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  exe_req_t exe_i,
  output logic     exe_ready_o,
  output wb_t      wb_o,
  input  logic     wb_ready_i
);

  bank_req_t            bank_req [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_ready;
  bank_rsp_t            bank_rsp [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_pop;
  ord_t                 ord_push;
  logic                 ord_ready;

  // ============================================================
  // Issue
  // ============================================================
  mem_issue u_issue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .exe_i        (exe_i),
    .exe_ready_o  (exe_ready_o),
    .bank_req_o   (bank_req),
    .bank_ready_i (bank_ready),
    .ord_o        (ord_push),
    .ord_ready_i  (ord_ready)
  );

  // ============================================================
  // Scratchpad banks, word interleaved
  // ============================================================
  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    mem_bank u_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush_i (flush_i),
      .req_i   (bank_req[k]),
      .ready_o (bank_ready[k]),
      .rsp_o   (bank_rsp[k]),
      .pop_i   (bank_pop[k])
    );
  end

  // In-order drain to writeback
  mem_writeback u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .ord_i       (ord_push),
    .ord_ready_o (ord_ready),
    .bank_rsp_i  (bank_rsp),
    .bank_pop_o  (bank_pop),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
  );

endmodule

`default_nettype wire

//--- source/mem_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module mem_writeback import mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  input  ord_t                 ord_i,
  output logic                 ord_ready_o,
  input  bank_rsp_t            bank_rsp_i [NUM_BANKS],
  output logic [NUM_BANKS-1:0] bank_pop_o,
  output wb_t                  wb_o,
  input  logic                 wb_ready_i
);

  ord_t                  q_mem [ORDQ_DEPTH];
  logic [ORDQ_PTR_W-1:0] wr_ptr;
  logic [ORDQ_PTR_W-1:0] rd_ptr;
  logic [ORDQ_PTR_W:0]   count;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;
  ord_t                  head;
  bank_rsp_t             head_rsp;
  logic [XLEN-1:0]       shifted;
  logic [XLEN-1:0]       load_data;

  // ============================================================
  // Order queue
  // ============================================================
  assign full        = (count == (ORDQ_PTR_W+1)'(ORDQ_DEPTH));
  assign empty       = (count == '0);
  assign ord_ready_o = ~full;
  assign push        = ord_i.valid;
  assign pop         = wb_o.valid & wb_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= ord_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ============================================================
  // Head extraction
  // ============================================================
  always_comb begin
    head     = q_mem[rd_ptr];
    head_rsp = bank_rsp_i[head.bank];
    shifted  = head_rsp.rdata >> {head.offset, 3'b000};

    case (head.align)
      ALIGN_B: load_data = head.sign_ext ? {{(XLEN-8){shifted[7]}}, shifted[7:0]} :
                                           {{(XLEN-8){1'b0}}, shifted[7:0]};
      ALIGN_H: load_data = head.sign_ext ? {{(XLEN-16){shifted[15]}}, shifted[15:0]} :
                                           {{(XLEN-16){1'b0}}, shifted[15:0]};
      default: load_data = head_rsp.rdata;
    endcase

    // Exception entries need no bank response
    wb_o.valid   = ~empty & (head.excp | head_rsp.valid);
    wb_o.we      = ~head.excp & ((head.mem_op == MEM_LOAD) | head.atomic);
    if (head.excp) begin
      wb_o.wdata = '0;
    end else if (head.mem_op == MEM_LOAD) begin
      wb_o.wdata = load_data;
    end else if (head.atomic) begin
      wb_o.wdata = {{(XLEN-1){1'b0}}, head.sc_ok};
    end else begin
      wb_o.wdata = '0;
    end
    wb_o.rob_idx = head.rob_idx;
    wb_o.pdest   = head.pdest;
    wb_o.excp    = head.excp;
    wb_o.vaddr   = head.vaddr;
    wb_o.mem_op  = head.mem_op;
    wb_o.atomic  = head.atomic;

    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_pop_o[k] = pop & ~head.excp & (head.bank == BANK_SEL_W'(k));
    end
  end

  // Issue must respect ord_ready
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> ~full);

  // Stalled record holds until accepted
  a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_o.valid && !wb_ready_i && !flush_i) |=> (wb_o.valid && $stable(wb_o)));

endmodule

`default_nettype wire

//--- source/mem_bank.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bank import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      flush_i,
  input  bank_req_t req_i,
  output logic      ready_o,
  output bank_rsp_t rsp_o,
  input  logic      pop_i
);

  logic [XLEN-1:0] mem [BANK_WORDS];
  logic            rsp_valid_q;
  logic [XLEN-1:0] rsp_data_q;
  logic            capture;

  // Response slot frees up in the same cycle it is popped
  assign ready_o = ~rsp_valid_q | pop_i;
  assign capture = req_i.valid & ready_o;

  // ============================================================
  // Storage
  // ============================================================
  always_ff @(posedge clk) begin
    if (capture && req_i.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.strb[b]) begin
          mem[req_i.row][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Old word is returned, stores ignore it downstream
  always_ff @(posedge clk) begin
    if (capture) begin
      rsp_data_q <= mem[req_i.row];
    end
  end

  // ============================================================
  // Response slot
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (flush_i) begin
      rsp_valid_q <= 1'b0;
    end else if (capture) begin
      rsp_valid_q <= 1'b1;
    end else if (pop_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rsp_data_q;

  // Writeback pops only what this bank holds
  a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> rsp_valid_q);

endmodule

`default_nettype wire

//--- source/mem_issue.sv
`timescale 1ns/100ps
`default_nettype none

module mem_issue import mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  input  exe_req_t             exe_i,
  output logic                 exe_ready_o,
  output bank_req_t            bank_req_o [NUM_BANKS],
  input  logic [NUM_BANKS-1:0] bank_ready_i,
  output ord_t                 ord_o,
  input  logic                 ord_ready_i
);

  exe_req_t              issue_q;
  logic [XLEN-1:0]       vaddr;
  logic [1:0]            offset;
  logic                  misalign;
  logic [BANK_SEL_W-1:0] bank_sel;
  logic [ROW_W-1:0]      row;
  logic [WORD_IDX_W-1:0] word_idx;
  logic [STRB_W-1:0]     strb;
  logic [XLEN-1:0]       lane_data;
  logic                  is_store;
  logic                  is_sc;
  logic                  is_ll;
  logic                  sc_ok;
  logic                  issue_fire;
  logic                  resv_valid;
  logic [WORD_IDX_W-1:0] resv_idx;

  // ============================================================
  // Issue register
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_q <= '0;
    end else if (flush_i) begin
      issue_q.valid <= 1'b0;
    end else if (exe_ready_o) begin
      issue_q <= exe_i;
    end
  end

  // ============================================================
  // Address, alignment and lanes
  // ============================================================
  always_comb begin
    vaddr    = issue_q.src0 + issue_q.imm;
    offset   = vaddr[1:0];
    bank_sel = vaddr[2 +: BANK_SEL_W];
    row      = vaddr[2 + BANK_SEL_W +: ROW_W];
    word_idx = vaddr[2 +: WORD_IDX_W];

    case (issue_q.align)
      ALIGN_B: begin
        misalign  = 1'b0;
        strb      = STRB_W'(1) << offset;
        lane_data = {(XLEN/8){issue_q.src1[7:0]}};
      end
      ALIGN_H: begin
        misalign  = offset[0];
        strb      = STRB_W'(3) << offset;
        lane_data = {(XLEN/16){issue_q.src1[15:0]}};
      end
      default: begin
        misalign  = |offset;
        strb      = '1;
        lane_data = issue_q.src1;
      end
    endcase

    is_store = (issue_q.mem_op == MEM_STORE);
    is_sc    = is_store & issue_q.atomic;
    is_ll    = ~is_store & issue_q.atomic;
    // SC succeeds only on a live reservation of the same word
    sc_ok    = is_sc & resv_valid & (resv_idx == word_idx) & ~misalign;
  end

  // Exceptions skip the bank and go straight to the order queue
  always_comb begin
    issue_fire  = issue_q.valid & ord_ready_i & (misalign | bank_ready_i[bank_sel]);
    exe_ready_o = ~issue_q.valid | issue_fire;
  end

  // ============================================================
  // Bank steering
  // ============================================================
  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_req_o[k].valid = issue_q.valid & ~misalign & ord_ready_i &
                            (bank_sel == BANK_SEL_W'(k));
      // Failed SC still reads so its queue entry gets a response
      bank_req_o[k].we    = is_store & (~is_sc | sc_ok);
      bank_req_o[k].strb  = strb;
      bank_req_o[k].row   = row;
      bank_req_o[k].wdata = lane_data;
    end
  end

  always_comb begin
    ord_o.valid    = issue_fire;
    ord_o.bank     = bank_sel;
    ord_o.excp     = misalign;
    ord_o.mem_op   = issue_q.mem_op;
    ord_o.align    = issue_q.align;
    ord_o.sign_ext = issue_q.sign_ext;
    ord_o.atomic   = issue_q.atomic;
    ord_o.sc_ok    = sc_ok;
    ord_o.offset   = offset;
    ord_o.rob_idx  = issue_q.rob_idx;
    ord_o.pdest    = issue_q.pdest;
    ord_o.vaddr    = vaddr;
  end

  // ============================================================
  // Load-linked reservation
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resv_valid <= 1'b0;
      resv_idx   <= '0;
    end else if (flush_i) begin
      resv_valid <= 1'b0;
    end else if (issue_fire) begin
      if (is_sc) begin
        resv_valid <= 1'b0;
      end else if (!misalign) begin
        if (is_ll) begin
          resv_valid <= 1'b1;
          resv_idx   <= word_idx;
        end else if (is_store && word_idx == resv_idx) begin
          resv_valid <= 1'b0;
        end
      end
    end
  end

  // A stalled operation stays in place until it leaves issue
  a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_q.valid && !issue_fire && !flush_i) |=> (issue_q.valid && $stable(issue_q)));

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // ============================================================
  // Sizes
  // ============================================================
  localparam int XLEN       = 32;
  localparam int STRB_W     = XLEN / 8;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 64;
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);
  localparam int ROW_W      = $clog2(BANK_WORDS);
  // Word index across all banks, bank bits are the low ones
  localparam int WORD_IDX_W = BANK_SEL_W + ROW_W;
  localparam int ROB_W      = 6;
  localparam int PREG_W     = 6;
  localparam int ORDQ_DEPTH = 4;
  localparam int ORDQ_PTR_W = $clog2(ORDQ_DEPTH);

  // ============================================================
  // Opcodes
  // ============================================================
  typedef enum logic [0:0] {
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    ALIGN_B,
    ALIGN_H,
    ALIGN_W
  } align_e;

  // ============================================================
  // Records
  // ============================================================

  // LL is an atomic load, SC an atomic store
  typedef struct packed {
    logic                valid;
    mem_op_e             mem_op;
    align_e              align;
    logic                sign_ext;
    logic                atomic;
    logic [XLEN-1:0]     src0;
    logic [XLEN-1:0]     src1;
    logic [XLEN-1:0]     imm;
    logic [ROB_W-1:0]    rob_idx;
    logic [PREG_W-1:0]   pdest;
  } exe_req_t;

  typedef struct packed {
    logic                valid;
    logic                we;
    logic [STRB_W-1:0]   strb;
    logic [ROW_W-1:0]    row;
    logic [XLEN-1:0]     wdata;
  } bank_req_t;

  typedef struct packed {
    logic                valid;
    logic [XLEN-1:0]     rdata;
  } bank_rsp_t;

  // valid marks a push into the order queue
  typedef struct packed {
    logic                  valid;
    logic [BANK_SEL_W-1:0] bank;
    logic                  excp;
    mem_op_e               mem_op;
    align_e                align;
    logic                  sign_ext;
    logic                  atomic;
    logic                  sc_ok;
    logic [1:0]            offset;
    logic [ROB_W-1:0]      rob_idx;
    logic [PREG_W-1:0]     pdest;
    logic [XLEN-1:0]       vaddr;
  } ord_t;

  typedef struct packed {
    logic                valid;
    logic                we;
    logic [XLEN-1:0]     wdata;
    logic [ROB_W-1:0]    rob_idx;
    logic [PREG_W-1:0]   pdest;
    logic                excp;
    logic [XLEN-1:0]     vaddr;
    mem_op_e             mem_op;
    logic                atomic;
  } wb_t;

endpackage

`default_nettype wire
